//--- list.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/pipeIf.sv
rtl/fetchStage.sv
rtl/controlUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/cpuCore.sv
verif/cpuCoreTb.sv

//--- verif/cpuCoreTb.sv
`include "cpu_macros.svh"

module cpuCoreTb;

    localparam int ImemAw     = $clog2(`CPU_IMEM_WORDS);
    localparam int DmemAw     = $clog2(`CPU_DMEM_WORDS);
    localparam int ClkPeriod  = 4;
    localparam int NumTests   = 6;
    localparam int TestCycles = 300;
    localparam int WaitCycles = 200;

    // ISA encodings
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opXori  = 6'h0e;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] fnSll   = 6'h00;
    localparam logic [5:0] fnSrl   = 6'h02;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnXor   = 6'h26;
    localparam logic [5:0] fnNor   = 6'h27;
    localparam logic [5:0] fnSlt   = 6'h2a;

    logic                     clk;
    logic                     rstN;
    logic                     run;
    logic                     imemWe;
    logic [ImemAw-1:0]        imemAddr;
    logic [`CPU_XLEN-1:0]     imemWdata;
    logic                     wbValid;
    logic [`CPU_REG_ADDR-1:0] wbReg;
    logic [`CPU_XLEN-1:0]     wbData;

    logic [31:0] prog [$];
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [`CPU_DMEM_WORDS];
    logic [4:0]  expReg [$];
    logic [31:0] expData [$];
    logic [4:0]  gotReg [$];
    logic [31:0] gotData [$];
    int          testErrors;
    int          totalErrors;
    int          testsRun;
    int          testsFailed;

    cpuCore cpuCore_inst (
        .clk       (clk),
        .rstN      (rstN),
        .run       (run),
        .imemWe    (imemWe),
        .imemAddr  (imemAddr),
        .imemWdata (imemWdata),
        .wbValid   (wbValid),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Records every register write the core reports
    initial begin
        forever begin
            @(negedge clk);
            if (wbValid === 1'b1) begin
                gotReg.push_back(wbReg);
                gotData.push_back(wbData);
            end
        end
    end

    initial begin
        #(NumTests * TestCycles * ClkPeriod);
        $display("Watchdog expired before the tests completed");
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Encoding and checking helpers

    function automatic logic [31:0] encR(input logic [5:0] fn, input int rs, rt, rd, sh);
        return {opRType, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input int rs, rt, imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] encJ(input int addr);
        return {opJ, addr[27:2]};
    endfunction

    task automatic checkValue(input string sig, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                     $time, sig, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkTrue(input bit ok, input string what);
        assert (ok)
        else begin
            $display("%s (time %0t)", what, $time);
            testErrors++;
        end
    endtask

    // Self-jump, then a nop in the slot fetched behind it
    task automatic endProgram();
        prog.push_back(encJ(prog.size() * 4));
        prog.push_back(32'h0);
    endtask

    ////////////////////////////////////////
    // ISA reference model

    task automatic runModel();
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] nextPc;
        logic [31:0] val;
        logic [4:0]  dest;
        logic        wr;
        bit          done;
        int          steps;
        expReg  = {};
        expData = {};
        pc      = '0;
        done    = 1'b0;
        steps   = 0;
        while (!done && steps < 500) begin
            instr  = ((pc >> 2) < prog.size()) ? prog[pc >> 2] : 32'h0;
            a      = modelRegs[instr[25:21]];
            b      = modelRegs[instr[20:16]];
            simm   = {{16{instr[15]}}, instr[15:0]};
            addr   = a + simm;
            nextPc = pc + 4;
            dest   = instr[20:16];
            wr     = 1'b1;
            val    = '0;
            case (instr[31:26])
                opRType: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        fnSll:   val = b << instr[10:6];
                        fnSrl:   val = b >> instr[10:6];
                        fnAdd:   val = a + b;
                        fnSub:   val = a - b;
                        fnAnd:   val = a & b;
                        fnOr:    val = a | b;
                        fnXor:   val = a ^ b;
                        fnNor:   val = ~(a | b);
                        fnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                opAddi:  val = a + simm;
                opSlti:  val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                opAndi:  val = a & {16'h0, instr[15:0]};
                opOri:   val = a | {16'h0, instr[15:0]};
                opXori:  val = a ^ {16'h0, instr[15:0]};
                opLw:    val = modelMem[addr[DmemAw+1:2]];
                opSw: begin
                    modelMem[addr[DmemAw+1:2]] = b;
                    wr = 1'b0;
                end
                opBeq, opBne: begin
                    if ((a == b) == (instr[31:26] == opBeq)) begin
                        nextPc = nextPc + {simm[29:0], 2'b00};
                    end
                    wr = 1'b0;
                end
                opJ: begin
                    nextPc = {nextPc[31:28], instr[25:0], 2'b00};
                    done   = (nextPc == pc);
                    wr     = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            // Register 0 stays zero
            if (wr && dest != 5'd0) begin
                modelRegs[dest] = val;
                expReg.push_back(dest);
                expData.push_back(val);
            end
            pc = nextPc;
            steps++;
        end
    endtask

    ////////////////////////////////////////
    // Test sequencing

    task automatic resetCore();
        @(posedge clk);
        run    <= 1'b0;
        imemWe <= 1'b0;
        rstN   <= 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            imemWe    <= 1'b1;
            imemAddr  <= ImemAw'(i);
            imemWdata <= prog[i];
        end
        @(posedge clk);
        imemWe <= 1'b0;
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        totalErrors += testErrors;
        if (testErrors == 0) begin
            $display("%-10s passed with %0d writes", name, gotReg.size());
        end else begin
            $display("%-10s failed with %0d errors", name, testErrors);
            testsFailed++;
        end
    endtask

    task automatic runProgram(input string name);
        int cycles;
        int i;
        testErrors = 0;
        resetCore();
        gotReg  = {};
        gotData = {};
        loadProgram();
        runModel();
        @(posedge clk);
        run <= 1'b1;
        cycles = 0;
        while (gotReg.size() < expReg.size() && cycles < WaitCycles) begin
            @(posedge clk);
            cycles++;
        end
        checkTrue(gotReg.size() >= expReg.size(), $sformatf(
            "%s timed out after %0d of %0d writes", name, gotReg.size(), expReg.size()));
        // Core now spins on the self-jump
        repeat (20) @(posedge clk);
        checkTrue(gotReg.size() <= expReg.size(), $sformatf(
            "%s wrote %0d registers where %0d were expected", name, gotReg.size(),
            expReg.size()));
        for (i = 0; i < expReg.size() && i < gotReg.size(); i++) begin
            checkValue("wbReg", expReg[i], gotReg[i]);
            checkValue("wbData", expData[i], gotData[i]);
        end
        @(posedge clk);
        run <= 1'b0;
        reportTest(name);
    endtask

    ////////////////////////////////////////
    // Tests

    task automatic testIdleLoad();
        int i;
        testErrors = 0;
        resetCore();
        gotReg  = {};
        gotData = {};
        prog    = {};
        for (i = 0; i < 8; i++) begin
            prog.push_back(encI(opAddi, 0, i + 1, i * 3 + 1));
        end
        loadProgram();
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            checkValue("wbValid", 32'd0, {31'd0, wbValid});
        end
        checkTrue(gotReg.size() == 0, "register write seen while run was low");
        reportTest("idleLoad");
    endtask

    task automatic testRType();
        prog = {};
        prog.push_back(encI(opAddi, 0, 1, 16'h0123));
        prog.push_back(encI(opAddi, 0, 2, -5));
        prog.push_back(encI(opAddi, 0, 3, 7));
        prog.push_back(encI(opAddi, 0, 4, 16'h0f0f));
        prog.push_back(encR(fnAdd, 1, 2, 5, 0));
        prog.push_back(encR(fnSub, 1, 2, 6, 0));
        prog.push_back(encR(fnAnd, 1, 4, 7, 0));
        prog.push_back(encR(fnOr, 3, 4, 8, 0));
        prog.push_back(encR(fnXor, 1, 4, 9, 0));
        prog.push_back(encR(fnNor, 2, 3, 10, 0));
        prog.push_back(encR(fnSlt, 2, 1, 11, 0));
        prog.push_back(encR(fnSlt, 1, 2, 12, 0));
        prog.push_back(encR(fnSll, 0, 4, 13, 4));
        prog.push_back(encR(fnSrl, 0, 2, 14, 3));
        endProgram();
        runProgram("rtype");
    endtask

    task automatic testIType();
        int          n;
        logic [15:0] imm;
        prog = {};
        for (n = 0; n < 4; n++) begin
            imm     = 16'($urandom());
            imm[15] = n[0];
            prog.push_back(encI(opAddi, 0, 1, imm));
            // Opposite sign for the second immediate
            imm     = 16'($urandom());
            imm[15] = ~n[0];
            prog.push_back(encI(opSlti, 1, 2, imm));
            prog.push_back(encI(opAndi, 1, 3, imm));
            prog.push_back(encI(opOri, 1, 4, imm));
            prog.push_back(encI(opXori, 1, 5, imm));
            prog.push_back(encI(opAddi, 1, 6, imm));
        end
        endProgram();
        runProgram("itype");
    endtask

    task automatic testLoadStore();
        prog = {};
        prog.push_back(encI(opAddi, 0, 1, 16'h55aa));
        prog.push_back(encI(opAddi, 0, 2, 16'hedcc));
        prog.push_back(encI(opAddi, 0, 8, 20));
        prog.push_back(encI(opSw, 0, 1, 8));
        prog.push_back(encI(opSw, 0, 2, 12));
        prog.push_back(encI(opLw, 0, 3, 8));
        prog.push_back(encR(fnAdd, 3, 3, 4, 0));
        prog.push_back(encI(opLw, 0, 5, 12));
        prog.push_back(encI(opSw, 0, 5, 16));
        prog.push_back(encI(opLw, 0, 6, 16));
        prog.push_back(encR(fnSub, 6, 1, 7, 0));
        prog.push_back(encI(opSw, 8, 1, 0));
        prog.push_back(encI(opLw, 8, 9, -4));
        prog.push_back(encR(fnXor, 9, 2, 10, 0));
        prog.push_back(encI(opSw, 0, 7, 8));
        prog.push_back(encI(opLw, 0, 11, 8));
        endProgram();
        runProgram("loadStore");
    endtask

    task automatic testBranches();
        prog = {};
        prog.push_back(encI(opAddi, 0, 1, 5));
        prog.push_back(encI(opAddi, 0, 2, 5));
        prog.push_back(encI(opAddi, 0, 3, 7));
        prog.push_back(encI(opBeq, 1, 2, 2));
        prog.push_back(encI(opAddi, 0, 10, 1));
        prog.push_back(encI(opAddi, 0, 11, 2));
        prog.push_back(encI(opBeq, 1, 3, 1));
        prog.push_back(encI(opAddi, 0, 12, 3));
        prog.push_back(encI(opBne, 1, 2, 1));
        prog.push_back(encI(opAddi, 0, 13, 4));
        prog.push_back(encI(opBne, 1, 3, 2));
        prog.push_back(encI(opAddi, 0, 14, 5));
        prog.push_back(encI(opAddi, 0, 15, 6));
        // Countdown loop with a backward branch
        prog.push_back(encI(opAddi, 0, 20, 3));
        prog.push_back(encI(opAddi, 20, 20, -1));
        prog.push_back(encI(opBne, 20, 0, -2));
        endProgram();
        runProgram("branches");
    endtask

    task automatic testJumpAndNops();
        prog = {};
        prog.push_back(encI(opAddi, 0, 1, 9));
        prog.push_back(encJ(16));
        prog.push_back(encI(opAddi, 0, 2, 1));
        prog.push_back(encI(opAddi, 0, 3, 2));
        prog.push_back(32'h0);
        prog.push_back(32'hfc04_0001);
        prog.push_back(encR(6'h3f, 1, 1, 5, 0));
        prog.push_back(encI(opAddi, 1, 6, 1));
        endProgram();
        runProgram("jumpNops");
    endtask

    initial begin
        void'($urandom(29));
        rstN         = 1'b0;
        run          = 1'b0;
        imemWe       = 1'b0;
        imemAddr     = '0;
        imemWdata    = '0;
        modelRegs[0] = '0;
        totalErrors  = 0;
        testsRun     = 0;
        testsFailed  = 0;
        testIdleLoad();
        testRType();
        testIType();
        testLoadStore();
        testBranches();
        testJumpAndNops();
        $display("Tests run %0d, tests failed %0d, check failures %0d",
                 testsRun, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/cpuCore.sv
`include "cpu_macros.svh"

module cpuCore (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               run,
    input  logic                               imemWe,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] imemAddr,
    input  logic [`CPU_XLEN-1:0]               imemWdata,
    output logic                               wbValid,
    output logic [`CPU_REG_ADDR-1:0]           wbReg,
    output logic [`CPU_XLEN-1:0]               wbData
);

    fetchIf fIf ();
    issueIf iIf ();
    memIf   mIf ();

    // Taken branch in execute also empties the fetch register
    assign fIf.flush = iIf.flush;

    fetchStage fetchStage_inst (
        .clk       (clk),
        .rstN      (rstN),
        .run       (run),
        .imemWe    (imemWe),
        .imemAddr  (imemAddr),
        .imemWdata (imemWdata),
        .fIf       (fIf.source),
        .redirect  (iIf.redirect),
        .target    (iIf.target)
    );

    decodeStage decodeStage_inst (
        .clk     (clk),
        .rstN    (rstN),
        .fIf     (fIf.sink),
        .iIf     (iIf.source),
        .mIf     (mIf.monitor),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData)
    );

    executeStage executeStage_inst (
        .clk  (clk),
        .rstN (rstN),
        .iIf  (iIf.sink),
        .mIf  (mIf.source)
    );

    memoryStage memoryStage_inst (
        .clk     (clk),
        .rstN    (rstN),
        .mIf     (mIf.sink),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData)
    );

endmodule

//--- rtl/memoryStage.sv
`include "cpu_macros.svh"

module memoryStage import cpuPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    memIf.sink                       mIf,
    output logic                     wbValid,
    output logic [`CPU_REG_ADDR-1:0] wbReg,
    output logic [`CPU_XLEN-1:0]     wbData
);

    localparam int DmemAw = $clog2(`CPU_DMEM_WORDS);

    logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_WORDS];
    memReqT               req;
    logic [DmemAw-1:0]    wordIdx;
    logic [`CPU_XLEN-1:0] loadData;

    assign req      = mIf.payload;
    assign wordIdx  = req.aluResult[DmemAw+1:2];
    assign loadData = dmem[wordIdx];

    always_ff @(posedge clk) begin
        if (mIf.valid && req.ctrl.memWrite) begin
            dmem[wordIdx] <= req.storeData;
        end
    end

    // Writeback triple; writes to register 0 are dropped here
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= mIf.valid && req.ctrl.regWrite && req.destReg != '0;
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= req.destReg;
        wbData <= req.ctrl.memToReg ? loadData : req.aluResult;
    end

    // Producer still in flight for the decode interlock
    assign mIf.busyDest  = req.destReg;
    assign mIf.busyWrite = mIf.valid && req.ctrl.regWrite;

    wordAligned: assert property (@(posedge clk) disable iff (!rstN)
        mIf.valid && (req.ctrl.memRead || req.ctrl.memWrite) |-> req.aluResult[1:0] == 2'b00)
        else $error("unaligned data memory address %h", req.aluResult);

endmodule

//--- rtl/executeStage.sv
`include "cpu_macros.svh"

module executeStage import cpuPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    issueIf.sink   iIf,
    memIf.source   mIf
);

    decodedT              op;
    memReqT               nextReq;
    logic [`CPU_XLEN-1:0] srcA;
    logic [`CPU_XLEN-1:0] srcB;
    logic [`CPU_XLEN-1:0] aluResult;
    logic [`CPU_XLEN-1:0] pcPlus4;
    logic [`CPU_XLEN-1:0] branchTarget;
    logic [`CPU_XLEN-1:0] jumpTarget;
    logic                 taken;

    assign op = iIf.payload;

    ////////////////////////////////////////
    // Operands and ALU

    assign srcA = op.ctrl.aluSrcA ? {{(`CPU_XLEN-5){1'b0}}, op.shamt} : op.rsVal;
    assign srcB = op.ctrl.aluSrcB ? op.imm32 : op.rtVal;

    always_comb begin
        case (op.ctrl.aluOp)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluNor:  aluResult = ~(srcA | srcB);
            aluXor:  aluResult = srcA ^ srcB;
            // Shift amount rides on operand A
            aluSll:  aluResult = srcB << srcA[4:0];
            aluSrl:  aluResult = srcB >> srcA[4:0];
            aluSlt:  aluResult = {{(`CPU_XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluEq:   aluResult = {{(`CPU_XLEN-1){1'b0}}, srcA == srcB};
            aluNe:   aluResult = {{(`CPU_XLEN-1){1'b0}}, srcA != srcB};
            default: aluResult = '0;
        endcase
    end

    ////////////////////////////////////////
    // Branch and jump resolution

    assign pcPlus4      = op.pc + 'd4;
    assign branchTarget = pcPlus4 + {op.imm32[`CPU_XLEN-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[`CPU_XLEN-1:28], op.jumpIndex, 2'b00};

    assign taken = iIf.valid && (op.ctrl.isJump || (op.ctrl.isBranch && aluResult[0]));

    // Single pulse, the flush empties the decode register that produced it
    assign iIf.redirect = taken;
    assign iIf.flush    = taken;
    assign iIf.target   = op.ctrl.isJump ? jumpTarget : branchTarget;

    // Execute register
    always_comb begin
        nextReq.ctrl.regWrite = op.ctrl.regWrite;
        nextReq.ctrl.memRead  = op.ctrl.memRead;
        nextReq.ctrl.memWrite = op.ctrl.memWrite;
        nextReq.ctrl.memToReg = op.ctrl.memToReg;
        nextReq.aluResult     = aluResult;
        nextReq.storeData     = op.rtVal;
        nextReq.destReg       = op.destReg;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mIf.valid <= 1'b0;
        end else begin
            mIf.valid <= iIf.valid;
        end
    end

    always_ff @(posedge clk) begin
        mIf.payload <= nextReq;
    end

endmodule

//--- rtl/decodeStage.sv
`include "cpu_macros.svh"

module decodeStage import cpuPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    fetchIf.sink                     fIf,
    issueIf.source                   iIf,
    memIf.monitor                    mIf,
    input  logic                     wbValid,
    input  logic [`CPU_REG_ADDR-1:0] wbReg,
    input  logic [`CPU_XLEN-1:0]     wbData
);

    logic [`CPU_XLEN-1:0]     regs [2**`CPU_REG_ADDR];
    logic [5:0]               opcode;
    logic [`CPU_REG_ADDR-1:0] rs;
    logic [`CPU_REG_ADDR-1:0] rt;
    logic [`CPU_REG_ADDR-1:0] rd;
    logic [`CPU_XLEN-1:0]     rsVal;
    logic [`CPU_XLEN-1:0]     rtVal;
    logic                     usesRs;
    logic                     usesRt;
    logic                     rsBusy;
    logic                     rtBusy;
    logic                     hazard;
    logic                     bubble;
    ctrlT                     ctrl;
    decodedT                  nextOp;

    assign opcode = fIf.instr[31:26];
    assign rs     = fIf.instr[25:21];
    assign rt     = fIf.instr[20:16];
    assign rd     = fIf.instr[15:11];

    ////////////////////////////////////////
    // Register file

    always_ff @(posedge clk) begin
        if (wbValid) begin
            regs[wbReg] <= wbData;
        end
    end

    // Same-cycle writeback is passed through
    assign rsVal = (rs == '0) ? '0 : (wbValid && wbReg == rs) ? wbData : regs[rs];
    assign rtVal = (rt == '0) ? '0 : (wbValid && wbReg == rt) ? wbData : regs[rt];

    ////////////////////////////////////////
    // Interlock against execute and memory

    assign usesRs = opcode != opJ;
    assign usesRt = opcode inside {opRType, opBeq, opBne, opSw};

    assign rsBusy = (rs != '0) &&
                    ((iIf.valid && iIf.payload.ctrl.regWrite && iIf.payload.destReg == rs) ||
                     (mIf.busyWrite && mIf.busyDest == rs));
    assign rtBusy = (rt != '0) &&
                    ((iIf.valid && iIf.payload.ctrl.regWrite && iIf.payload.destReg == rt) ||
                     (mIf.busyWrite && mIf.busyDest == rt));

    assign hazard    = fIf.valid && ((usesRs && rsBusy) || (usesRt && rtBusy));
    assign fIf.stall = hazard;
    assign bubble    = hazard || !fIf.valid || iIf.flush;

    controlUnit controlUnit_inst (
        .instr  (fIf.instr),
        .hazard (bubble),
        .ctrl   (ctrl)
    );

    ////////////////////////////////////////
    // Decode register

    always_comb begin
        nextOp.ctrl      = ctrl;
        nextOp.pc        = fIf.pc;
        nextOp.rsVal     = rsVal;
        nextOp.rtVal     = rtVal;
        nextOp.imm32     = ctrl.immZero ? {16'b0, fIf.instr[15:0]} :
                                          {{16{fIf.instr[15]}}, fIf.instr[15:0]};
        nextOp.shamt     = fIf.instr[10:6];
        nextOp.destReg   = ctrl.regDst ? rd : rt;
        nextOp.jumpIndex = fIf.instr[25:0];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            iIf.valid <= 1'b0;
        end else begin
            iIf.valid <= !bubble;
        end
    end

    always_ff @(posedge clk) begin
        iIf.payload <= nextOp;
    end

    noWriteToZero: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbReg != '0)
        else $error("register file write at index 0");

endmodule

//--- rtl/controlUnit.sv
module controlUnit import cpuPkg::*; (
    input  logic [31:0] instr,
    input  logic        hazard,
    output ctrlT        ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl = '0;

        if (hazard) begin
            // Bubble
            ctrl = '0;
        end else if (instr == 32'b0) begin
            // Zero word decodes as a nop
            ctrl = '0;
        end else if (opcode == opRType) begin
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            case (funct)
                fnAdd: ctrl.aluOp = aluAdd;
                fnSub: ctrl.aluOp = aluSub;
                fnAnd: ctrl.aluOp = aluAnd;
                fnOr:  ctrl.aluOp = aluOr;
                fnNor: ctrl.aluOp = aluNor;
                fnXor: ctrl.aluOp = aluXor;
                fnSlt: ctrl.aluOp = aluSlt;
                fnSll: begin
                    ctrl.aluOp   = aluSll;
                    ctrl.aluSrcA = 1'b1;
                end
                fnSrl: begin
                    ctrl.aluOp   = aluSrl;
                    ctrl.aluSrcA = 1'b1;
                end
                default: ctrl = '0;
            endcase
        end else begin
            // I-type and J-type
            ctrl.aluSrcB = 1'b1;
            case (opcode)
                opAddi: ctrl.regWrite = 1'b1;
                opSlti: begin
                    ctrl.aluOp    = aluSlt;
                    ctrl.regWrite = 1'b1;
                end
                opAndi, opOri, opXori: begin
                    ctrl.aluOp    = (opcode == opAndi) ? aluAnd :
                                    (opcode == opOri)  ? aluOr  : aluXor;
                    ctrl.immZero  = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                opLw: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = 1'b1;
                end
                opSw: ctrl.memWrite = 1'b1;
                opBeq, opBne: begin
                    ctrl.aluOp    = (opcode == opBeq) ? aluEq : aluNe;
                    ctrl.aluSrcB  = 1'b0;
                    ctrl.isBranch = 1'b1;
                end
                opJ: begin
                    ctrl.aluSrcB = 1'b0;
                    ctrl.isJump  = 1'b1;
                end
                default: ctrl = '0;
            endcase
        end
    end

endmodule

//--- rtl/fetchStage.sv
`include "cpu_macros.svh"

module fetchStage (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               run,
    input  logic                               imemWe,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] imemAddr,
    input  logic [`CPU_XLEN-1:0]               imemWdata,
    fetchIf.source                             fIf,
    input  logic                               redirect,
    input  logic [`CPU_XLEN-1:0]               target
);

    localparam int ImemAw = $clog2(`CPU_IMEM_WORDS);

    logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_WORDS];
    logic [`CPU_XLEN-1:0] pcReg;
    logic [ImemAw-1:0]    pcIdx;
    logic                 advance;

    assign pcIdx   = pcReg[ImemAw+1:2];
    assign advance = run && !fIf.stall;

    // Program load, only while halted
    always_ff @(posedge clk) begin
        if (imemWe && !run) begin
            imem[imemAddr] <= imemWdata;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg <= '0;
        end else if (redirect) begin
            pcReg <= target;
        end else if (advance) begin
            pcReg <= pcReg + 'd4;
        end
    end

    // Flush wins over a stall; halting drains the register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fIf.valid <= 1'b0;
        end else if (fIf.flush) begin
            fIf.valid <= 1'b0;
        end else if (!fIf.stall) begin
            fIf.valid <= run;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !redirect) begin
            fIf.instr <= imem[pcIdx];
            fIf.pc    <= pcReg;
        end
    end

    noLoadWhileRunning: assert property (@(posedge clk) disable iff (!rstN) imemWe |-> !run)
        else $error("imemWe raised while run is high");

endmodule

//--- rtl/pipeIf.sv
`include "cpu_macros.svh"

// Fetch register to decode
interface fetchIf;
    logic                 valid;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] instr;
    logic                 stall;
    logic                 flush;

    modport source (output valid, pc, instr, input stall, flush);
    modport sink   (input valid, pc, instr, output stall);
endinterface

// Decode register to execute, redirect back
interface issueIf import cpuPkg::*; ();
    logic                 valid;
    decodedT              payload;
    logic                 flush;
    logic                 redirect;
    logic [`CPU_XLEN-1:0] target;

    modport source (output valid, payload, input flush);
    modport sink   (input valid, payload, output flush, redirect, target);
endinterface

// Execute register to memory, busy info back to decode
interface memIf import cpuPkg::*; ();
    logic                     valid;
    memReqT                   payload;
    logic [`CPU_REG_ADDR-1:0] busyDest;
    logic                     busyWrite;

    modport source  (output valid, payload);
    modport sink    (input valid, payload, output busyDest, busyWrite);
    modport monitor (input busyDest, busyWrite);
endinterface

//--- rtl/cpuPkg.sv
`include "cpu_macros.svh"

package cpuPkg;

    // Primary opcodes
    localparam logic [5:0] opRType = 6'b000000;
    localparam logic [5:0] opJ     = 6'b000010;
    localparam logic [5:0] opBeq   = 6'b000100;
    localparam logic [5:0] opBne   = 6'b000101;
    localparam logic [5:0] opAddi  = 6'b001000;
    localparam logic [5:0] opSlti  = 6'b001010;
    localparam logic [5:0] opAndi  = 6'b001100;
    localparam logic [5:0] opOri   = 6'b001101;
    localparam logic [5:0] opXori  = 6'b001110;
    localparam logic [5:0] opLw    = 6'b100011;
    localparam logic [5:0] opSw    = 6'b101011;

    // R-type function codes
    localparam logic [5:0] fnSll = 6'b000000;
    localparam logic [5:0] fnSrl = 6'b000010;
    localparam logic [5:0] fnAdd = 6'b100000;
    localparam logic [5:0] fnSub = 6'b100010;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr  = 6'b100101;
    localparam logic [5:0] fnXor = 6'b100110;
    localparam logic [5:0] fnNor = 6'b100111;
    localparam logic [5:0] fnSlt = 6'b101010;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluNor = 4'd4,
        aluXor = 4'd5,
        aluSll = 4'd6,
        aluSrl = 4'd7,
        aluSlt = 4'd8,
        aluEq  = 4'd9,
        aluNe  = 4'd10
    } aluOpT;

    // Decoder outputs, all zero for a bubble
    typedef struct packed {
        aluOpT aluOp;
        logic  regDst;
        logic  aluSrcA;
        logic  aluSrcB;
        logic  immZero;
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  isBranch;
        logic  isJump;
    } ctrlT;

    // Controls that survive past execute
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
    } memCtrlT;

    typedef struct packed {
        ctrlT                     ctrl;
        logic [`CPU_XLEN-1:0]     pc;
        logic [`CPU_XLEN-1:0]     rsVal;
        logic [`CPU_XLEN-1:0]     rtVal;
        logic [`CPU_XLEN-1:0]     imm32;
        logic [4:0]               shamt;
        logic [`CPU_REG_ADDR-1:0] destReg;
        logic [25:0]              jumpIndex;
    } decodedT;

    typedef struct packed {
        memCtrlT                  ctrl;
        logic [`CPU_XLEN-1:0]     aluResult;
        logic [`CPU_XLEN-1:0]     storeData;
        logic [`CPU_REG_ADDR-1:0] destReg;
    } memReqT;

endpackage

//--- rtl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define CPU_XLEN 32

// Register index width
`define CPU_REG_ADDR 5

// Instruction memory depth in words
`define CPU_IMEM_WORDS 64

// Data memory depth in words
`define CPU_DMEM_WORDS 64

`endif
